//--- cart_loader_top.f
logic/cart_loader_pkg.sv
logic/load_stream_if.sv
logic/download_router.sv
logic/rom_header_probe.sv
logic/cheat_code_assembler.sv
logic/backup_ram_sequencer.sv
logic/cart_loader_top.sv
bench/cart_loader_asserts.sv
bench/cart_loader_tb.sv

//--- Bender.yml
package:
  name: cart_loader

sources:
  - logic/cart_loader_pkg.sv
  - logic/load_stream_if.sv
  - logic/download_router.sv
  - logic/rom_header_probe.sv
  - logic/cheat_code_assembler.sv
  - logic/backup_ram_sequencer.sv
  - logic/cart_loader_top.sv
  - target: test
    files:
      - bench/cart_loader_asserts.sv
      - bench/cart_loader_tb.sv

//--- bench/cart_loader_tb.sv
// Testbench for the cartridge loader; runs a table of cart and code downloads with sector replies
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb;
	import cart_loader_pkg::*;

	localparam int LBA_WIDTH  = 32;
	localparam int NUM_ROWS   = 6;
	localparam int ROW_CYCLES = 5000;

	// One table row with cart header, save image, code list and expected header results
	typedef struct packed {
		header_mode_e     mode;
		logic [15:0]      word0;
		logic [15:0]      word2;
		logic [15:0]      rom_word;
		logic [15:0]      ram_word;
		logic             mounted;
		logic [7:0][15:0] codes;
		logic [7:0]       exp_type;
		logic [23:0]      exp_rom_mask;
		logic [23:0]      exp_ram_mask;
		logic             exp_region;
	} row_t;

	logic                 clk_sys;
	logic                 reset;
	logic                 dl_active;
	logic [7:0]           dl_index;
	logic [DL_ADDR_W-1:0] dl_addr;
	logic [DL_DATA_W-1:0] dl_data;
	logic                 dl_wr;
	header_mode_e         header_mode;
	logic                 img_mounted;
	logic                 img_readonly;
	logic [63:0]          img_size;
	logic                 bk_load_req;
	logic                 bk_save_req;
	logic                 autosave;
	logic                 osd_open;
	logic                 bsram_write;
	logic                 sd_ack;

	logic [7:0]           rom_type;
	logic [MASK_W-1:0]    rom_mask;
	logic [MASK_W-1:0]    ram_mask;
	logic                 rom_region;
	logic [31:0]          code_flags;
	logic [31:0]          code_addr;
	logic [31:0]          code_compare;
	logic [31:0]          code_replace;
	logic                 code_valid;
	logic                 code_clear;
	logic [LBA_WIDTH-1:0] sd_lba;
	logic                 sd_rd;
	logic                 sd_wr;
	logic                 bk_loading;
	logic                 bk_busy;
	logic                 bk_pending;
	logic                 bk_ena;
	logic                 cart_loading;
	logic                 activity_led;

	row_t                 rows [NUM_ROWS];
	integer               seed = 87699;
	int                   valid_count = 0;
	int                   clear_count = 0;
	logic [LBA_WIDTH-1:0] req_lba [$];
	logic                 req_write [$];

	cart_loader_top #(
		.LBA_WIDTH (LBA_WIDTH)
	) dut0 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.dl_wr        (dl_wr),
		.header_mode  (header_mode),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.rom_type     (rom_type),
		.rom_mask     (rom_mask),
		.ram_mask     (ram_mask),
		.rom_region   (rom_region),
		.code_flags   (code_flags),
		.code_addr    (code_addr),
		.code_compare (code_compare),
		.code_replace (code_replace),
		.code_valid   (code_valid),
		.code_clear   (code_clear),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_loading   (bk_loading),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.bk_ena       (bk_ena),
		.cart_loading (cart_loading),
		.activity_led (activity_led)
	);

	bind backup_ram_sequencer cart_loader_asserts #(.LBA_WIDTH(LBA_WIDTH)) seq_asserts (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sd_ack     (sd_ack),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.sd_lba     (sd_lba),
		.code_valid (1'b0)
	);

	bind cheat_code_assembler cart_loader_asserts code_asserts (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sd_ack     (1'b0),
		.sd_rd      (1'b0),
		.sd_wr      (1'b0),
		.sd_lba     (32'd0),
		.code_valid (code_valid)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	// ==================================================
	// Helpers
	// ==================================================
	task automatic step_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic fail_run();
		$display("Test failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic compare_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			fail_run();
		end
	endtask

	// One-cycle host strobe followed by an idle cycle
	task automatic write_word(input logic [DL_ADDR_W-1:0] addr, input logic [DL_DATA_W-1:0] data);
		dl_addr = addr;
		dl_data = data;
		dl_wr   = 1'b1;
		step_cycle();
		dl_wr   = 1'b0;
		step_cycle();
	endtask

	task automatic wait_busy_start(output bit started);
		started = 1'b0;
		for (int i = 0; i < 8 && !started; i++) begin
			step_cycle();
			started = bk_busy;
		end
	endtask

	// Waits out one backup run and checks every request the responder saw
	task automatic check_sector_run(input int sectors, input bit is_write);
		bit started;
		wait_busy_start(started);
		if (sectors == 0) begin
			compare_value("bk_busy", started, 1'b0);
			compare_value("request count", req_lba.size(), 0);
		end else begin
			if (!started) begin
				$display("Backup transfer did not start at %0t ns", $time);
				fail_run();
			end
			while (bk_busy) begin
				compare_value("bk_loading", bk_loading, !is_write);
				step_cycle();
			end
			compare_value("request count", req_lba.size(), sectors);
			foreach (req_lba[i]) begin
				compare_value("sd_lba", req_lba[i], i);
				compare_value("sd_wr", req_write[i], is_write);
			end
		end
		compare_value("sd_rd/sd_wr", {sd_rd, sd_wr}, 2'b00);
	endtask

	task automatic load_cartridge(input row_t row);
		logic [DL_ADDR_W-1:0] size_addr;
		case (row.mode)
			MODE_HIROM:   size_addr = HIROM_SIZE_ADDR;
			MODE_EXHIROM: size_addr = EXHIROM_SIZE_ADDR;
			default:      size_addr = LOROM_SIZE_ADDR;
		endcase
		header_mode  = row.mode;
		dl_index     = 8'h00;
		img_mounted  = row.mounted;
		img_readonly = 1'b0;
		img_size     = row.mounted ? 64'h0000_8000 : 64'h0;
		dl_active    = 1'b1;
		step_cycle();
		compare_value("cart_loading", cart_loading, 1'b1);
		write_word('0, row.word0);
		write_word(DL_ADDR_W'(2), row.word2);
		for (int off = 4; off < 16; off += 2) begin
			write_word(DL_ADDR_W'(off), 16'($random(seed)));
		end
		write_word(size_addr, row.rom_word);
		write_word(size_addr + RAM_SIZE_OFFSET, row.ram_word);
		// Hold active so the enable sees the final RAM size
		repeat (3) step_cycle();
		dl_active = 1'b0;
	endtask

	task automatic save_on_menu_open(input int sectors);
		req_lba.delete();
		req_write.delete();
		bsram_write = 1'b1;
		step_cycle();
		bsram_write = 1'b0;
		step_cycle();
		compare_value("bk_pending", bk_pending, 1'b1);
		compare_value("activity_led", activity_led, 1'b1);
		osd_open = 1'b1;
		check_sector_run(sectors, 1'b1);
		compare_value("bk_pending", bk_pending, 1'b0);
		osd_open = 1'b0;
		step_cycle();
	endtask

	task automatic load_code_list(input logic [7:0][15:0] words);
		int waited;
		valid_count = 0;
		clear_count = 0;
		dl_index    = CODE_INDEX;
		dl_active   = 1'b1;
		step_cycle();
		compare_value("cart_loading", cart_loading, 1'b0);
		for (int k = 0; k < 8; k++) begin
			write_word(DL_ADDR_W'(2 * k), words[k]);
		end
		waited = 0;
		while (valid_count == 0 && waited < 8) begin
			step_cycle();
			waited++;
		end
		if (valid_count == 0) begin
			$display("code_valid never pulsed after the code list at %0t ns", $time);
			fail_run();
		end
		dl_active = 1'b0;
		dl_index  = 8'h00;
		repeat (2) step_cycle();
		compare_value("code_valid pulses", valid_count, 1);
		compare_value("code_clear pulses", clear_count, 1);
		// Flags first, each field low word first
		compare_value("code_flags", code_flags, {words[1], words[0]});
		compare_value("code_addr", code_addr, {words[3], words[2]});
		compare_value("code_compare", code_compare, {words[5], words[4]});
		compare_value("code_replace", code_replace, {words[7], words[6]});
	endtask

	task automatic run_row(input row_t row);
		int sectors;
		sectors = 0;
		if (row.mounted && row.exp_ram_mask != '0) begin
			sectors = int'(row.exp_ram_mask >> SECTOR_BYTES_LOG2) + 1;
		end
		req_lba.delete();
		req_write.delete();
		load_cartridge(row);
		compare_value("rom_type", rom_type, row.exp_type);
		compare_value("rom_mask", rom_mask, row.exp_rom_mask);
		compare_value("ram_mask", ram_mask, row.exp_ram_mask);
		compare_value("rom_region", rom_region, row.exp_region);
		compare_value("bk_ena", bk_ena, sectors != 0);
		check_sector_run(sectors, 1'b0);
		compare_value("cart_loading", cart_loading, 1'b0);
		if (sectors != 0) begin
			save_on_menu_open(sectors);
		end
		load_code_list(row.codes);
	endtask

	// ==================================================
	// Sector responder and strobe monitor
	// ==================================================
	initial begin : sector_responder
		int hold;
		sd_ack = 1'b0;
		forever begin
			step_cycle();
			if (sd_rd || sd_wr) begin
				req_lba.push_back(sd_lba);
				req_write.push_back(sd_wr);
				hold = 1 + ({$random(seed)} % 4);
				repeat (2) step_cycle();
				sd_ack = 1'b1;
				repeat (hold) step_cycle();
				sd_ack = 1'b0;
			end
		end
	end

	always begin
		@(posedge clk_sys);
		#20;
		if (code_valid) valid_count = valid_count + 1;
		if (code_clear) clear_count = clear_count + 1;
	end

	initial begin : watchdog
		repeat (NUM_ROWS * ROW_CYCLES) @(posedge clk_sys);
		$display("Timeout: the run did not finish within %0d cycles", NUM_ROWS * ROW_CYCLES);
		fail_run();
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		// Code words listed w7 down to w0
		rows[0] = '{MODE_AUTO, 16'h211B, 16'h0100, 16'h0000, 16'h0000, 1'b1,
			128'h1111_0001_7E00_1234_00AB_00CD_8000_0042, 8'h21, 24'h1FFFFF, 24'h0007FF, 1'b1};
		rows[1] = '{MODE_AUTO, 16'h3000, 16'hFEFF, 16'h0000, 16'h0000, 1'b1,
			128'hDEAD_BEEF_0000_FFFF_0012_3456_0000_0001, 8'h30, 24'h3FFFFF, 24'h000000, 1'b0};
		rows[2] = '{MODE_LOROM, 16'hA5C7, 16'h01FF, 16'h0A00, 16'h0002, 1'b1,
			128'h0F0F_F0F0_5555_AAAA_007E_C000_4000_0010, 8'h00, 24'h0FFFFF, 24'h000FFF, 1'b1};
		rows[3] = '{MODE_HIROM, 16'h5A00, 16'h0000, 16'h3D00, 16'h00F3, 1'b0,
			128'h0123_4567_89AB_CDEF_00C0_FFEE_0000_8001, 8'h01, 24'h7FFFFF, 24'h001FFF, 1'b0};
		rows[4] = '{MODE_EXHIROM, 16'h0000, 16'h0100, 16'h0E00, 16'h0001, 1'b1,
			128'h8000_0000_0000_0001_00FF_0F00_1234_5678, 8'h02, 24'hFFFFFF, 24'h0007FF, 1'b1};
		rows[5] = '{MODE_NONE, 16'h2434, 16'h0000, 16'h0900, 16'h0004, 1'b1,
			128'h7777_6666_5555_4444_3333_2222_1111_0000, 8'h00, 24'h3FFFFF, 24'h000000, 1'b0};

		reset        = 1'b0;
		dl_active    = 1'b0;
		dl_index     = 8'h00;
		dl_addr      = '0;
		dl_data      = '0;
		dl_wr        = 1'b0;
		header_mode  = MODE_AUTO;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_size     = 64'h0;
		bk_load_req  = 1'b0;
		bk_save_req  = 1'b0;
		autosave     = 1'b0;
		osd_open     = 1'b0;
		bsram_write  = 1'b0;

		repeat (4) @(posedge clk_sys);
		#10;
		reset    = 1'b1;
		autosave = 1'b1;
		step_cycle();

		// Control outputs come out of reset low
		compare_value("sd_rd", sd_rd, 1'b0);
		compare_value("sd_wr", sd_wr, 1'b0);
		compare_value("bk_busy", bk_busy, 1'b0);
		compare_value("bk_loading", bk_loading, 1'b0);
		compare_value("bk_pending", bk_pending, 1'b0);
		compare_value("bk_ena", bk_ena, 1'b0);
		compare_value("code_valid", code_valid, 1'b0);
		compare_value("code_clear", code_clear, 1'b0);
		compare_value("rom_region", rom_region, 1'b0);

		for (int r = 0; r < NUM_ROWS; r++) begin
			run_row(rows[r]);
		end

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/cart_loader_asserts.sv
// Concurrent checks on the sector handshake and code strobe, bound into the loader blocks
`timescale 1ns/1ps
`default_nettype none

module cart_loader_asserts #(
	parameter int LBA_WIDTH = 32
) (
	input wire                 clk_sys,
	input wire                 reset,
	input wire                 sd_ack,
	input wire                 sd_rd,
	input wire                 sd_wr,
	input wire [LBA_WIDTH-1:0] sd_lba,
	input wire                 code_valid
);

	// One transfer direction at a time
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high together");

	// Host acknowledge takes the request down
	req_drops_after_ack: assert property (@(posedge clk_sys) disable iff (!reset)
		$rose(sd_ack) |=> !(sd_rd || sd_wr))
		else $error("Sector request still high one cycle after sd_ack rose");

	valid_single_pulse: assert property (@(posedge clk_sys) disable iff (!reset)
		code_valid |=> !code_valid)
		else $error("code_valid held high for more than one cycle");

	lba_stable_in_request: assert property (@(posedge clk_sys) disable iff (!reset)
		(sd_rd || sd_wr) |=> (!(sd_rd || sd_wr) || $stable(sd_lba)))
		else $error("sd_lba changed while a sector request was high");

endmodule

`default_nettype wire

//--- logic/cart_loader_top.sv
// Cartridge loader top level; connects the host download and sector ports to the loader blocks
`timescale 1ns/1ps
`default_nettype none

module cart_loader_top #(
	parameter int LBA_WIDTH = 32
) (
	input  wire                                    clk_sys,
	input  wire                                    reset,

	// Host download
	input  wire                                    dl_active,
	input  wire [7:0]                              dl_index,
	input  wire [cart_loader_pkg::DL_ADDR_W-1:0]   dl_addr,
	input  wire [cart_loader_pkg::DL_DATA_W-1:0]   dl_data,
	input  wire                                    dl_wr,
	input  cart_loader_pkg::header_mode_e          header_mode,

	// Save image and user controls
	input  wire                                    img_mounted,
	input  wire                                    img_readonly,
	input  wire [63:0]                             img_size,
	input  wire                                    bk_load_req,
	input  wire                                    bk_save_req,
	input  wire                                    autosave,
	input  wire                                    osd_open,
	input  wire                                    bsram_write,
	input  wire                                    sd_ack,

	// Cartridge description
	output logic [7:0]                             rom_type,
	output logic [cart_loader_pkg::MASK_W-1:0]     rom_mask,
	output logic [cart_loader_pkg::MASK_W-1:0]     ram_mask,
	output logic                                   rom_region,

	// Cheat code
	output logic [31:0]                            code_flags,
	output logic [31:0]                            code_addr,
	output logic [31:0]                            code_compare,
	output logic [31:0]                            code_replace,
	output logic                                   code_valid,
	output logic                                   code_clear,

	// Sector requests and status
	output logic [LBA_WIDTH-1:0]                   sd_lba,
	output logic                                   sd_rd,
	output logic                                   sd_wr,
	output logic                                   bk_loading,
	output logic                                   bk_busy,
	output logic                                   bk_pending,
	output logic                                   bk_ena,
	output logic                                   cart_loading,
	output logic                                   activity_led
);
	import cart_loader_pkg::*;

	cheat_code_u code_word;

	load_stream_if cart_stream ();
	load_stream_if code_stream ();

	download_router u_router (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.dl_addr   (dl_addr),
		.dl_data   (dl_data),
		.dl_wr     (dl_wr),
		.cart      (cart_stream.source),
		.code      (code_stream.source)
	);

	rom_header_probe u_probe (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.header_mode (header_mode),
		.cart        (cart_stream.sink),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.rom_region  (rom_region)
	);

	cheat_code_assembler u_codes (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.code       (code_stream.sink),
		.cart       (cart_stream.sink),
		.code_word  (code_word),
		.code_valid (code_valid),
		.code_clear (code_clear)
	);

	backup_ram_sequencer #(
		.LBA_WIDTH (LBA_WIDTH)
	) u_backup (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart         (cart_stream.sink),
		.ram_mask     (ram_mask),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.bk_load_req  (bk_load_req),
		.bk_save_req  (bk_save_req),
		.autosave     (autosave),
		.osd_open     (osd_open),
		.bsram_write  (bsram_write),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_loading   (bk_loading),
		.bk_busy      (bk_busy),
		.bk_pending   (bk_pending),
		.bk_ena       (bk_ena),
		.activity_led (activity_led)
	);

	// Field view of the assembled code
	assign code_flags   = code_word.fields.flags;
	assign code_addr    = code_word.fields.addr;
	assign code_compare = code_word.fields.compare;
	assign code_replace = code_word.fields.replace;

	assign cart_loading = cart_stream.active;

endmodule

`default_nettype wire

//--- logic/backup_ram_sequencer.sv
// Moves backup RAM to and from host sectors; autoload after cart, manual and autosave
`timescale 1ns/1ps
`default_nettype none

module backup_ram_sequencer #(
	parameter int LBA_WIDTH = 32
) (
	input  wire                                clk_sys,
	input  wire                                reset,
	load_stream_if.sink                        cart,
	input  wire [cart_loader_pkg::MASK_W-1:0]  ram_mask,
	input  wire                                img_mounted,
	input  wire                                img_readonly,
	input  wire [63:0]                         img_size,
	input  wire                                bk_load_req,
	input  wire                                bk_save_req,
	input  wire                                autosave,
	input  wire                                osd_open,
	input  wire                                bsram_write,
	input  wire                                sd_ack,
	output logic [LBA_WIDTH-1:0]               sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic                               bk_loading,
	output logic                               bk_busy,
	output logic                               bk_pending,
	output logic                               bk_ena,
	output logic                               activity_led
);
	import cart_loader_pkg::*;

	logic                 save_trig;
	logic                 old_load;
	logic                 old_save;
	logic                 old_ack;
	logic                 load_edge;
	logic                 save_edge;
	logic                 auto_load;
	logic [LBA_WIDTH-1:0] last_lba;

	// Autosave fires when the menu opens with unsaved data
	assign save_trig = bk_save_req | (bk_pending & osd_open & autosave);
	assign load_edge = bk_load_req & bk_ena & ~old_load;
	assign save_edge = save_trig & bk_ena & ~old_save;
	assign auto_load = cart.finish & (|img_size) & bk_ena;
	assign last_lba  = LBA_WIDTH'(ram_mask >> SECTOR_BYTES_LOG2);

	// ==================================================
	// Enable and pending tracking
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			if (cart.start) begin
				bk_ena <= 1'b0;
			end
			// The save image is mounted by the time the cart finishes
			if (cart.active && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end

			if (bk_ena && !osd_open && bsram_write) begin
				bk_pending <= 1'b1;
			end else if (bk_busy) begin
				bk_pending <= 1'b0;
			end
		end
	end

	// ==================================================
	// Sector transfer sequence
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
		end else begin
			old_load <= bk_load_req & bk_ena;
			old_save <= save_trig & bk_ena;
			old_ack  <= sd_ack;

			// Host has taken the request
			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_edge || save_edge) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_edge;
					sd_lba     <= '0;
					sd_rd      <= load_edge;
					sd_wr      <= ~load_edge;
				end
				// Cart end wins over a manual request in the same cycle
				if (auto_load) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin
				if (sd_lba >= last_lba) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + LBA_WIDTH'(1);
					sd_rd  <= bk_loading;
					sd_wr  <= ~bk_loading;
				end
			end
		end
	end

	assign activity_led = cart.active | (autosave & bk_pending);

endmodule

`default_nettype wire

//--- logic/cheat_code_assembler.sv
// Collects eight code-stream words into one cheat code and signals valid and clear
`timescale 1ns/1ps
`default_nettype none

module cheat_code_assembler (
	input  wire                          clk_sys,
	input  wire                          reset,
	load_stream_if.sink                  code,
	load_stream_if.sink                  cart,
	output cart_loader_pkg::cheat_code_u code_word,
	output logic                         code_valid,
	output logic                         code_clear
);

	logic [2:0] slot;
	logic       last_word;
	logic       first_word;

	// Each code is 16 bytes, so bits 3:1 pick the word
	assign slot       = code.addr[3:1];
	assign last_word  = code.wr && (slot == 3'd7) && !cart.active;
	assign first_word = code.wr && (code.addr == '0);

	// Word slots fill in arrival order
	always_ff @(posedge clk_sys) begin
		if (code.wr) begin
			code_word.words[slot[2:1]][slot[0]] <= code.data;
		end
	end

	// ==================================================
	// Strobes
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			code_valid <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_valid <= last_word;
			// New list or new cartridge drops all stored codes
			code_clear <= first_word | cart.active;
		end
	end

endmodule

`default_nettype wire

//--- logic/rom_header_probe.sv
// Watches the cartridge stream for header fields and derives ROM type, masks and region
`timescale 1ns/1ps
`default_nettype none

module rom_header_probe (
	input  wire                                    clk_sys,
	input  wire                                    reset,
	input  cart_loader_pkg::header_mode_e          header_mode,
	load_stream_if.sink                            cart,
	output logic [7:0]                             rom_type,
	output logic [cart_loader_pkg::MASK_W-1:0]     rom_mask,
	output logic [cart_loader_pkg::MASK_W-1:0]     ram_mask,
	output logic                                   rom_region
);
	import cart_loader_pkg::*;

	localparam logic [DL_ADDR_W-1:0] REGION_ADDR = 25'd2;
	localparam logic [MASK_W-1:0]    MASK_BASE   = 24'd1024;

	logic [3:0]           rom_size;
	logic [3:0]           ram_size;
	logic [DL_ADDR_W-1:0] size_addr;
	logic                 size_en;

	// Forced modes know where their header sits
	always_comb begin
		size_addr = LOROM_SIZE_ADDR;
		size_en   = 1'b1;
		case (header_mode)
			MODE_LOROM:   size_addr = LOROM_SIZE_ADDR;
			MODE_HIROM:   size_addr = HIROM_SIZE_ADDR;
			MODE_EXHIROM: size_addr = EXHIROM_SIZE_ADDR;
			default:      size_en = 1'b0;
		endcase
	end

	// ==================================================
	// Header capture
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size   <= DEFAULT_ROM_SIZE;
			ram_size   <= 4'h0;
			rom_type   <= 8'h00;
			rom_region <= 1'b0;
		end else if (cart.wr) begin
			if (cart.addr == '0) begin
				rom_size <= DEFAULT_ROM_SIZE;
				ram_size <= 4'h0;
				// Loader-built images carry the size codes in the first byte
				if (header_mode == MODE_AUTO && cart.data[7:0] != 8'h00) begin
					{ram_size, rom_size} <= cart.data[7:0];
				end
				case (header_mode)
					MODE_NONE,
					MODE_LOROM:   rom_type <= 8'h00;
					MODE_HIROM:   rom_type <= 8'h01;
					MODE_EXHIROM: rom_type <= 8'h02;
					default:      rom_type <= cart.data[15:8];
				endcase
			end

			if (cart.addr == REGION_ADDR) begin
				rom_region <= cart.data[8];
			end

			// ROM size code in the high byte, RAM code in the low nibble two bytes on
			if (size_en && cart.addr == size_addr) begin
				rom_size <= cart.data[11:8];
			end
			if (size_en && cart.addr == size_addr + RAM_SIZE_OFFSET) begin
				ram_size <= cart.data[3:0];
			end
		end
	end

	// Size code n selects 1 KB << n
	assign rom_mask = (MASK_BASE << rom_size) - MASK_W'(1);
	assign ram_mask = (ram_size != 4'h0) ? (MASK_BASE << ram_size) - MASK_W'(1) : '0;

endmodule

`default_nettype wire

//--- logic/download_router.sv
// Splits the host download into cartridge and code streams, registered, with edge pulses
`timescale 1ns/1ps
`default_nettype none

module download_router (
	input  wire                                    clk_sys,
	input  wire                                    reset,
	input  wire                                    dl_active,
	input  wire [7:0]                              dl_index,
	input  wire [cart_loader_pkg::DL_ADDR_W-1:0]   dl_addr,
	input  wire [cart_loader_pkg::DL_DATA_W-1:0]   dl_data,
	input  wire                                    dl_wr,
	load_stream_if.source                          cart,
	load_stream_if.source                          code
);
	import cart_loader_pkg::*;

	logic is_code;
	logic cart_next;
	logic code_next;

	assign is_code   = (dl_index == CODE_INDEX);
	assign cart_next = dl_active & ~is_code;
	assign code_next = dl_active & is_code;

	// ==================================================
	// Control, cleared by reset
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart.active <= 1'b0;
			cart.start  <= 1'b0;
			cart.finish <= 1'b0;
			cart.wr     <= 1'b0;
			code.active <= 1'b0;
			code.start  <= 1'b0;
			code.finish <= 1'b0;
			code.wr     <= 1'b0;
		end else begin
			// The registered active doubles as the previous level
			cart.active <= cart_next;
			cart.start  <= cart_next & ~cart.active;
			cart.finish <= ~cart_next & cart.active;
			cart.wr     <= dl_wr & cart_next;

			code.active <= code_next;
			code.start  <= code_next & ~code.active;
			code.finish <= ~code_next & code.active;
			code.wr     <= dl_wr & code_next;
		end
	end

	// Payload is only looked at under wr
	always_ff @(posedge clk_sys) begin
		cart.addr <= dl_addr;
		cart.data <= dl_data;
		code.addr <= dl_addr;
		code.data <= dl_data;
	end

endmodule

`default_nettype wire

//--- logic/load_stream_if.sv
// One routed download stream; the router drives it and the loader blocks read it
`timescale 1ns/1ps
`default_nettype none

interface load_stream_if;
	import cart_loader_pkg::*;

	// Download in progress, with edge pulses
	logic                 active;
	logic                 start;
	logic                 finish;

	// Word strobe and payload
	logic                 wr;
	logic [DL_ADDR_W-1:0] addr;
	logic [DL_DATA_W-1:0] data;

	modport source (
		output active,
		output start,
		output finish,
		output wr,
		output addr,
		output data
	);

	modport sink (
		input active,
		input start,
		input finish,
		input wr,
		input addr,
		input data
	);

endinterface

`default_nettype wire

//--- logic/cart_loader_pkg.sv
// Shared types and constants for the cartridge loader; imported by every loader block
`default_nettype none

package cart_loader_pkg;

	// ==================================================
	// Download stream geometry
	// ==================================================
	localparam int DL_ADDR_W = 25;
	localparam int DL_DATA_W = 16;
	localparam int MASK_W    = 24;

	// Host index reserved for the cheat code list
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// 512 bytes per backup sector
	localparam int SECTOR_BYTES_LOG2 = 9;

	// ==================================================
	// Cartridge header
	// ==================================================
	typedef enum logic [2:0] {
		MODE_AUTO    = 3'd0,
		MODE_NONE    = 3'd1,
		MODE_LOROM   = 3'd2,
		MODE_HIROM   = 3'd3,
		MODE_EXHIROM = 3'd4
	} header_mode_e;

	// Copier header in front of the image shifts every native address
	localparam logic [DL_ADDR_W-1:0] HDR_COPIER_BYTES  = 25'h000200;
	localparam logic [DL_ADDR_W-1:0] LOROM_SIZE_ADDR   = 25'h007FD6 + HDR_COPIER_BYTES;
	localparam logic [DL_ADDR_W-1:0] HIROM_SIZE_ADDR   = 25'h00FFD6 + HDR_COPIER_BYTES;
	localparam logic [DL_ADDR_W-1:0] EXHIROM_SIZE_ADDR = 25'h40FFD6 + HDR_COPIER_BYTES;
	localparam logic [DL_ADDR_W-1:0] RAM_SIZE_OFFSET   = 25'd2;

	// 12 gives a 4 MB ROM window
	localparam logic [3:0] DEFAULT_ROM_SIZE = 4'hC;

	// ==================================================
	// Cheat code word
	// ==================================================
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	// words[pair][half] follows arrival order: pair 0 is flags, half 0 the low word
	typedef union packed {
		logic [0:3][1:0][DL_DATA_W-1:0] words;
		cheat_fields_t                  fields;
	} cheat_code_u;

endpackage

`default_nettype wire
